//--- hw/isaPkg.sv
package isaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OpSpecial = 6'h00,
        OpJ       = 6'h02,
        OpBeq     = 6'h04,
        OpBne     = 6'h05,
        OpAddiu   = 6'h09,
        OpOri     = 6'h0d,
        OpLui     = 6'h0f,
        OpLw      = 6'h23,
        OpSw      = 6'h2b
    } opcodeE;

    // SPECIAL function field, bits 5:0
    typedef enum logic [5:0] {
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnSlt  = 6'h2a
    } functE;

    ////////////////////
    // Instruction field layouts
    ////////////////////
    typedef struct packed {
        logic [5:0] opcode;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        regIdxT      rs;
        regIdxT      rt;
        logic [15:0] imm;
    } iTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jTypeT;

    // SLL r0 by zero, decodes to nothing
    localparam wordT NopWord = 32'h0000_0000;

endpackage

//--- hw/pipePkg.sv
package pipePkg;

    // ALU function selected in decode
    typedef enum logic [2:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluXor = 3'd4,
        AluSlt = 3'd5,
        AluLui = 3'd6
    } aluOpE;

    // Where an EX operand comes from
    typedef enum logic [1:0] {
        FwdReg = 2'd0,
        FwdMem = 2'd1,
        FwdWb  = 2'd2
    } fwdSelE;

    // Control-transfer kind, resolved in EX
    typedef enum logic [1:0] {
        BrNone = 2'd0,
        BrEq   = 2'd1,
        BrNe   = 2'd2,
        BrJump = 2'd3
    } branchE;

endpackage

//--- hw/fetchUnit.sv
`timescale 1ns/100ps

module fetchUnit #(
    parameter isaPkg::wordT resetPc = 32'h0000_0000
) (
    input  logic         clk,
    input  logic         rstN,
    input  logic         stall,
    input  logic         branchTaken,
    input  isaPkg::wordT branchTarget,
    input  isaPkg::wordT instData,
    output isaPkg::wordT instAddr,
    output isaPkg::wordT idPc,
    output isaPkg::wordT idInst
);

    isaPkg::wordT pc;
    isaPkg::wordT nextPc;

    assign instAddr = pc;

    // Redirect from EX wins over sequential fetch
    assign nextPc = branchTaken ? branchTarget : pc + 32'd4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= resetPc;
            idPc   <= resetPc;
            idInst <= isaPkg::NopWord;
        end else begin
            if (branchTaken || !stall) begin
                pc <= nextPc;
            end
            // Squash the wrong-path fetch
            if (branchTaken) begin
                idInst <= isaPkg::NopWord;
            end else if (!stall) begin
                idPc   <= pc;
                idInst <= instData;
            end
        end
    end

endmodule

//--- hw/decodeUnit.sv
`timescale 1ns/100ps

module decodeUnit (
    input  logic            clk,
    input  logic            rstN,
    input  logic            stall,
    input  logic            flush,
    input  isaPkg::wordT    idPc,
    input  isaPkg::wordT    idInst,
    output isaPkg::regIdxT  rsIdx,
    output isaPkg::regIdxT  rtIdx,
    input  isaPkg::wordT    rsData,
    input  isaPkg::wordT    rtData,
    output isaPkg::wordT    exPc,
    output isaPkg::regIdxT  exRs,
    output isaPkg::regIdxT  exRt,
    output isaPkg::regIdxT  exDest,
    output isaPkg::wordT    exA,
    output isaPkg::wordT    exB,
    output isaPkg::wordT    exImm,
    output pipePkg::aluOpE  exAluOp,
    output logic            exUseImm,
    output pipePkg::branchE exBranch,
    output logic            exMemRe,
    output logic            exMemWe,
    output logic            exRegWe
);

    isaPkg::rTypeT   rInst;
    isaPkg::iTypeT   iInst;
    isaPkg::jTypeT   jInst;
    isaPkg::opcodeE  opcode;
    isaPkg::functE   funct;
    isaPkg::wordT    pcPlus4;
    isaPkg::regIdxT  dest;
    isaPkg::wordT    imm;
    pipePkg::aluOpE  aluOp;
    logic            useImm;
    pipePkg::branchE branch;
    logic            memRe;
    logic            memWe;
    logic            regWe;
    logic            bubble;

    assign rInst   = idInst;
    assign iInst   = idInst;
    assign jInst   = idInst;
    assign opcode  = isaPkg::opcodeE'(rInst.opcode);
    assign funct   = isaPkg::functE'(rInst.funct);
    assign pcPlus4 = idPc + 32'd4;
    assign rsIdx   = rInst.rs;
    assign rtIdx   = rInst.rt;
    assign bubble  = stall || flush;

    ////////////////////
    // Decode
    ////////////////////
    always_comb begin
        dest   = iInst.rt;
        imm    = {{16{iInst.imm[15]}}, iInst.imm};
        aluOp  = pipePkg::AluAdd;
        useImm = 1'b1;
        branch = pipePkg::BrNone;
        memRe  = 1'b0;
        memWe  = 1'b0;
        regWe  = 1'b0;
        case (opcode)
            isaPkg::OpSpecial: begin
                dest   = rInst.rd;
                useImm = 1'b0;
                regWe  = 1'b1;
                case (funct)
                    isaPkg::FnAddu: aluOp = pipePkg::AluAdd;
                    isaPkg::FnSubu: aluOp = pipePkg::AluSub;
                    isaPkg::FnAnd:  aluOp = pipePkg::AluAnd;
                    isaPkg::FnOr:   aluOp = pipePkg::AluOr;
                    isaPkg::FnXor:  aluOp = pipePkg::AluXor;
                    isaPkg::FnSlt:  aluOp = pipePkg::AluSlt;
                    // Unsupported function, NOP included
                    default:        regWe = 1'b0;
                endcase
            end
            isaPkg::OpAddiu: regWe = 1'b1;
            isaPkg::OpOri: begin
                aluOp = pipePkg::AluOr;
                imm   = {16'h0000, iInst.imm};
                regWe = 1'b1;
            end
            isaPkg::OpLui: begin
                aluOp = pipePkg::AluLui;
                regWe = 1'b1;
            end
            isaPkg::OpLw: begin
                memRe = 1'b1;
                regWe = 1'b1;
            end
            isaPkg::OpSw:  memWe = 1'b1;
            isaPkg::OpBeq: branch = pipePkg::BrEq;
            isaPkg::OpBne: branch = pipePkg::BrNe;
            isaPkg::OpJ: begin
                branch = pipePkg::BrJump;
                // Absolute target rides in the immediate slot
                imm    = {pcPlus4[31:28], jInst.target, 2'b00};
            end
            default: ;
        endcase
    end

    ////////////////////
    // ID/EX register
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exBranch <= pipePkg::BrNone;
            exMemRe  <= 1'b0;
            exMemWe  <= 1'b0;
            exRegWe  <= 1'b0;
        end else begin
            exBranch <= bubble ? pipePkg::BrNone : branch;
            exMemRe  <= memRe && !bubble;
            exMemWe  <= memWe && !bubble;
            exRegWe  <= regWe && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        exPc     <= idPc;
        exRs     <= rsIdx;
        exRt     <= rtIdx;
        exDest   <= dest;
        exA      <= rsData;
        exB      <= rtData;
        exImm    <= imm;
        exAluOp  <= aluOp;
        exUseImm <= useImm;
    end

endmodule

//--- hw/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  isaPkg::regIdxT rsIdx,
    input  isaPkg::regIdxT rtIdx,
    output isaPkg::wordT   rsData,
    output isaPkg::wordT   rtData,
    input  logic           wbWe,
    input  isaPkg::regIdxT wbDest,
    input  isaPkg::wordT   wbData
);

    isaPkg::wordT regs [32];

    // R0 is hardwired, a same-cycle WB write bypasses the array
    function automatic isaPkg::wordT readPort(
        input isaPkg::regIdxT idx,
        input logic           we,
        input isaPkg::regIdxT wIdx,
        input isaPkg::wordT   wData,
        input isaPkg::wordT   stored
    );
        if (idx == 5'd0) begin
            return 32'h0000_0000;
        end else if (we && wIdx == idx) begin
            return wData;
        end
        return stored;
    endfunction

    assign rsData = readPort(rsIdx, wbWe, wbDest, wbData, regs[rsIdx]);
    assign rtData = readPort(rtIdx, wbWe, wbDest, wbData, regs[rtIdx]);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else if (wbWe && wbDest != 5'd0) begin
            regs[wbDest] <= wbData;
        end
    end

endmodule

//--- hw/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
    input  isaPkg::regIdxT  rsIdx,
    input  isaPkg::regIdxT  rtIdx,
    input  isaPkg::regIdxT  exRs,
    input  isaPkg::regIdxT  exRt,
    input  isaPkg::regIdxT  exDest,
    input  logic            exMemRe,
    input  isaPkg::regIdxT  memDest,
    input  logic            memRegWe,
    input  isaPkg::regIdxT  wbDest,
    input  logic            wbWe,
    output logic            stall,
    output pipePkg::fwdSelE fwdA,
    output pipePkg::fwdSelE fwdB
);

    // Youngest producer wins, so MEM is checked before WB
    function automatic pipePkg::fwdSelE pickSource(
        input isaPkg::regIdxT src,
        input isaPkg::regIdxT mDest,
        input logic           mWe,
        input isaPkg::regIdxT wDest,
        input logic           wWe
    );
        if (src == 5'd0) begin
            return pipePkg::FwdReg;
        end else if (mWe && mDest == src) begin
            return pipePkg::FwdMem;
        end else if (wWe && wDest == src) begin
            return pipePkg::FwdWb;
        end
        return pipePkg::FwdReg;
    endfunction

    assign fwdA = pickSource(exRs, memDest, memRegWe, wbDest, wbWe);
    assign fwdB = pickSource(exRt, memDest, memRegWe, wbDest, wbWe);

    // Load data is not ready until WB, hold ID one cycle
    assign stall = exMemRe && exDest != 5'd0 && (exDest == rsIdx || exDest == rtIdx);

endmodule

//--- hw/executeUnit.sv
`timescale 1ns/100ps

module executeUnit (
    input  logic            clk,
    input  logic            rstN,
    input  isaPkg::wordT    exPc,
    input  isaPkg::regIdxT  exDest,
    input  isaPkg::wordT    exA,
    input  isaPkg::wordT    exB,
    input  isaPkg::wordT    exImm,
    input  pipePkg::aluOpE  exAluOp,
    input  logic            exUseImm,
    input  pipePkg::branchE exBranch,
    input  logic            exMemRe,
    input  logic            exMemWe,
    input  logic            exRegWe,
    input  pipePkg::fwdSelE fwdA,
    input  pipePkg::fwdSelE fwdB,
    output isaPkg::wordT    memResult,
    input  isaPkg::wordT    wbData,
    output logic            branchTaken,
    output isaPkg::wordT    branchTarget,
    output isaPkg::regIdxT  memDest,
    output logic            memRegWe,
    output isaPkg::wordT    memWData,
    output logic            memRe,
    output logic            memWe
);

    isaPkg::wordT opA;
    isaPkg::wordT opB;
    isaPkg::wordT aluB;
    isaPkg::wordT aluOut;

    ////////////////////
    // Operand forwarding
    ////////////////////
    function automatic isaPkg::wordT fwdMux(
        input pipePkg::fwdSelE sel,
        input isaPkg::wordT    regVal,
        input isaPkg::wordT    memVal,
        input isaPkg::wordT    wbVal
    );
        case (sel)
            pipePkg::FwdMem: return memVal;
            pipePkg::FwdWb:  return wbVal;
            default:         return regVal;
        endcase
    endfunction

    assign opA  = fwdMux(fwdA, exA, memResult, wbData);
    assign opB  = fwdMux(fwdB, exB, memResult, wbData);
    assign aluB = exUseImm ? exImm : opB;

    ////////////////////
    // ALU
    ////////////////////
    always_comb begin
        case (exAluOp)
            pipePkg::AluAdd: aluOut = opA + aluB;
            pipePkg::AluSub: aluOut = opA - aluB;
            pipePkg::AluAnd: aluOut = opA & aluB;
            pipePkg::AluOr:  aluOut = opA | aluB;
            pipePkg::AluXor: aluOut = opA ^ aluB;
            pipePkg::AluSlt: aluOut = {31'd0, $signed(opA) < $signed(aluB)};
            pipePkg::AluLui: aluOut = {aluB[15:0], 16'h0000};
            default:         aluOut = opA + aluB;
        endcase
    end

    // Branch decision on forwarded operands
    always_comb begin
        case (exBranch)
            pipePkg::BrEq:   branchTaken = opA == opB;
            pipePkg::BrNe:   branchTaken = opA != opB;
            pipePkg::BrJump: branchTaken = 1'b1;
            default:         branchTaken = 1'b0;
        endcase
    end

    assign branchTarget = (exBranch == pipePkg::BrJump) ? exImm
                        : exPc + 32'd4 + {exImm[29:0], 2'b00};

    ////////////////////
    // EX/MEM register
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memRegWe <= 1'b0;
            memRe    <= 1'b0;
            memWe    <= 1'b0;
        end else begin
            memRegWe <= exRegWe;
            memRe    <= exMemRe;
            memWe    <= exMemWe;
        end
    end

    always_ff @(posedge clk) begin
        memResult <= aluOut;
        memDest   <= exDest;
        memWData  <= opB;
    end

endmodule

//--- hw/memWriteback.sv
`timescale 1ns/100ps

module memWriteback (
    input  logic           clk,
    input  logic           rstN,
    input  isaPkg::wordT   memResult,
    input  isaPkg::regIdxT memDest,
    input  logic           memRegWe,
    input  logic           memRe,
    input  isaPkg::wordT   memRData,
    output logic           wbWe,
    output isaPkg::regIdxT wbDest,
    output isaPkg::wordT   wbData
);

    logic         wbIsLoad;
    isaPkg::wordT wbResult;
    isaPkg::wordT wbLoad;

    // MEM/WB control
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbWe     <= 1'b0;
            wbIsLoad <= 1'b0;
        end else begin
            wbWe     <= memRegWe;
            wbIsLoad <= memRe;
        end
    end

    always_ff @(posedge clk) begin
        wbDest   <= memDest;
        wbResult <= memResult;
        wbLoad   <= memRData;
    end

    // Loads return memory data, everything else the ALU result
    assign wbData = wbIsLoad ? wbLoad : wbResult;

endmodule

//--- hw/mipsCore.sv
`timescale 1ns/100ps

module mipsCore #(
    parameter isaPkg::wordT resetPc = 32'h0000_0000
) (
    input  logic         clk,
    input  logic         rstN,
    output isaPkg::wordT instAddr,
    input  isaPkg::wordT instData,
    output isaPkg::wordT memAddr,
    output isaPkg::wordT memWData,
    input  isaPkg::wordT memRData,
    output logic         memRe,
    output logic         memWe
);

    ////////////////////
    // IF/ID and ID side
    ////////////////////
    isaPkg::wordT    idPc;
    isaPkg::wordT    idInst;
    isaPkg::regIdxT  rsIdx;
    isaPkg::regIdxT  rtIdx;
    isaPkg::wordT    rsData;
    isaPkg::wordT    rtData;

    ////////////////////
    // ID/EX
    ////////////////////
    isaPkg::wordT    exPc;
    isaPkg::regIdxT  exRs;
    isaPkg::regIdxT  exRt;
    isaPkg::regIdxT  exDest;
    isaPkg::wordT    exA;
    isaPkg::wordT    exB;
    isaPkg::wordT    exImm;
    pipePkg::aluOpE  exAluOp;
    logic            exUseImm;
    pipePkg::branchE exBranch;
    logic            exMemRe;
    logic            exMemWe;
    logic            exRegWe;

    // Hazard and redirect
    logic            stall;
    pipePkg::fwdSelE fwdA;
    pipePkg::fwdSelE fwdB;
    logic            branchTaken;
    isaPkg::wordT    branchTarget;

    // EX/MEM and MEM/WB
    isaPkg::regIdxT  memDest;
    logic            memRegWe;
    logic            wbWe;
    isaPkg::regIdxT  wbDest;
    isaPkg::wordT    wbData;

    fetchUnit #(
        .resetPc(resetPc)
    ) u_fetchUnit (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .instData(instData),
        .instAddr(instAddr),
        .idPc(idPc),
        .idInst(idInst)
    );

    decodeUnit u_decodeUnit (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .flush(branchTaken),
        .idPc(idPc),
        .idInst(idInst),
        .rsIdx(rsIdx),
        .rtIdx(rtIdx),
        .rsData(rsData),
        .rtData(rtData),
        .exPc(exPc),
        .exRs(exRs),
        .exRt(exRt),
        .exDest(exDest),
        .exA(exA),
        .exB(exB),
        .exImm(exImm),
        .exAluOp(exAluOp),
        .exUseImm(exUseImm),
        .exBranch(exBranch),
        .exMemRe(exMemRe),
        .exMemWe(exMemWe),
        .exRegWe(exRegWe)
    );

    regFile u_regFile (
        .clk(clk),
        .rstN(rstN),
        .rsIdx(rsIdx),
        .rtIdx(rtIdx),
        .rsData(rsData),
        .rtData(rtData),
        .wbWe(wbWe),
        .wbDest(wbDest),
        .wbData(wbData)
    );

    hazardUnit u_hazardUnit (
        .rsIdx(rsIdx),
        .rtIdx(rtIdx),
        .exRs(exRs),
        .exRt(exRt),
        .exDest(exDest),
        .exMemRe(exMemRe),
        .memDest(memDest),
        .memRegWe(memRegWe),
        .wbDest(wbDest),
        .wbWe(wbWe),
        .stall(stall),
        .fwdA(fwdA),
        .fwdB(fwdB)
    );

    // ALU result held in EX/MEM is also the data address
    executeUnit u_executeUnit (
        .clk(clk),
        .rstN(rstN),
        .exPc(exPc),
        .exDest(exDest),
        .exA(exA),
        .exB(exB),
        .exImm(exImm),
        .exAluOp(exAluOp),
        .exUseImm(exUseImm),
        .exBranch(exBranch),
        .exMemRe(exMemRe),
        .exMemWe(exMemWe),
        .exRegWe(exRegWe),
        .fwdA(fwdA),
        .fwdB(fwdB),
        .memResult(memAddr),
        .wbData(wbData),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .memDest(memDest),
        .memRegWe(memRegWe),
        .memWData(memWData),
        .memRe(memRe),
        .memWe(memWe)
    );

    memWriteback u_memWriteback (
        .clk(clk),
        .rstN(rstN),
        .memResult(memAddr),
        .memDest(memDest),
        .memRegWe(memRegWe),
        .memRe(memRe),
        .memRData(memRData),
        .wbWe(wbWe),
        .wbDest(wbDest),
        .wbData(wbData)
    );

endmodule

//--- verif/mipsCore_checker.sv
`timescale 1ns/100ps

module mipsCore_checker (
    input logic         clk,
    input logic         rstN,
    input isaPkg::wordT instAddr,
    input isaPkg::wordT memAddr,
    input logic         memRe,
    input logic         memWe
);

    // Only one data access per cycle
    readWriteExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(memRe && memWe))
        else $error("memRe and memWe are high in the same cycle");

    // Data port stays idle in reset
    idleInReset: assert property (@(posedge clk) !rstN |-> (!memRe && !memWe))
        else $error("Data port is active while rstN is low");

    fetchAligned: assert property (@(posedge clk) disable iff (!rstN)
        instAddr[1:0] == 2'b00)
        else $error("instAddr is not word-aligned");

    dataAligned: assert property (@(posedge clk) disable iff (!rstN)
        (memRe || memWe) |-> memAddr[1:0] == 2'b00)
        else $error("memAddr is not word-aligned during an access");

endmodule

bind mipsCore mipsCore_checker u_checker (
    .clk(clk),
    .rstN(rstN),
    .instAddr(instAddr),
    .memAddr(memAddr),
    .memRe(memRe),
    .memWe(memWe)
);

//--- verif/mipsCore_tb.sv
`timescale 1ns/100ps

module mipsCore_tb;

    localparam int ProgLen    = 48;
    localparam int DumpLen    = 31;
    localparam int TotalLen   = ProgLen + DumpLen + 1;
    localparam int NumProgs   = 20;
    localparam int ImemWords  = 128;
    // 256-byte data window
    localparam int DmemWords  = 64;
    localparam int CycleLimit = NumProgs * (3 * TotalLen + 20);
    localparam logic [31:0] ResetPc = 32'h0000_0000;

    logic        clk;
    logic        rstN;
    logic [31:0] instAddr;
    logic [31:0] instData;
    logic [31:0] memAddr;
    logic [31:0] memWData;
    logic [31:0] memRData;
    logic        memRe;
    logic        memWe;

    int          seed;
    int          cycleCount;
    int          progNum;
    int          storeIdx;
    int          loadIdx;
    logic [31:0] imem [ImemWords];
    logic [31:0] dmem [DmemWords];
    logic [31:0] modelMem [DmemWords];
    logic [31:0] modelRegs [32];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] expLoad [$];
    logic        pendWe;
    logic [5:0]  pendIdx;
    logic [31:0] pendData;

    mipsCore #(
        .resetPc(ResetPc)
    ) u_mipsCore (
        .clk(clk),
        .rstN(rstN),
        .instAddr(instAddr),
        .instData(instData),
        .memAddr(memAddr),
        .memWData(memWData),
        .memRData(memRData),
        .memRe(memRe),
        .memWe(memWe)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CycleLimit) begin
            $display("Timeout: the run went past %0d cycles without finishing", CycleLimit);
            $display("*** TEST FAILED ***");
            $fatal(1, "Timeout");
        end
    end

    ////////////////////
    // Memory models
    ////////////////////
    always @(negedge clk) begin
        instData = imem[instAddr[8:2]];
        memRData = dmem[memAddr[7:2]];
        pendWe   = 1'b0;
        if (rstN && memRe) begin
            checkLoad(memAddr);
        end
        if (rstN && memWe) begin
            checkStore(memAddr, memWData);
            pendWe   = 1'b1;
            pendIdx  = memAddr[7:2];
            pendData = memWData;
        end
    end

    // Store lands at the rising edge
    always @(posedge clk) begin
        if (pendWe) begin
            dmem[pendIdx] = pendData;
        end
    end

    task automatic compareValues(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
        if (storeIdx >= expAddr.size()) begin
            $display("Program %0d stored %h to %h but the model makes no such store",
                     progNum, data, addr);
            $display("*** TEST FAILED ***");
            $fatal(1, "Unexpected store");
        end else begin
            compareValues($sformatf("prog%0d store%0d address", progNum, storeIdx),
                          expAddr[storeIdx], addr);
            compareValues($sformatf("prog%0d store%0d data", progNum, storeIdx),
                          expData[storeIdx], data);
            storeIdx = storeIdx + 1;
        end
    endtask

    task automatic checkLoad(input logic [31:0] addr);
        if (loadIdx >= expLoad.size()) begin
            $display("Program %0d read %h but the model makes no such load",
                     progNum, addr);
            $display("*** TEST FAILED ***");
            $fatal(1, "Unexpected load");
        end else begin
            compareValues($sformatf("prog%0d load%0d address", progNum, loadIdx),
                          expLoad[loadIdx], addr);
            loadIdx = loadIdx + 1;
        end
    endtask

    ////////////////////
    // Program generation
    ////////////////////
    function automatic logic [31:0] rTypeWord(input logic [5:0] fn, input logic [4:0] rd,
                                              input logic [4:0] rs, input logic [4:0] rt);
        return {6'(isaPkg::OpSpecial), rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iTypeWord(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Absolute J to instruction slot idx
    function automatic logic [31:0] jumpWord(input int idx);
        return {6'(isaPkg::OpJ), 26'((ResetPc >> 2) + 32'(idx))};
    endfunction

    // Mostly r0..r7 so that dependencies are frequent
    function automatic logic [4:0] pickReg();
        logic [31:0] r;
        r = $unsigned($random(seed));
        return (r[9:8] == 2'b00) ? r[4:0] : {2'b00, r[2:0]};
    endfunction

    function automatic logic [5:0] pickFunct();
        case ($unsigned($random(seed)) % 6)
            0:       return isaPkg::FnAddu;
            1:       return isaPkg::FnSubu;
            2:       return isaPkg::FnAnd;
            3:       return isaPkg::FnOr;
            4:       return isaPkg::FnXor;
            default: return isaPkg::FnSlt;
        endcase
    endfunction

    task automatic buildProgram();
        int unsigned kind;
        int unsigned maxOff;
        logic [15:0] off;
        logic [15:0] imm;
        logic [15:0] offset;
        // Every unused slot is a J to itself
        for (int i = 0; i < ImemWords; i++) begin
            imem[i] = jumpWord(i);
        end
        for (int k = 0; k < ProgLen; k++) begin
            kind   = $unsigned($random(seed)) % 10;
            imm    = 16'($random(seed));
            offset = 16'(($unsigned($random(seed)) % DmemWords) * 4);
            maxOff = (ProgLen - 1 - k > 5) ? 5 : ProgLen - 1 - k;
            off    = 16'($unsigned($random(seed)) % (maxOff + 1));
            case (kind)
                0, 1, 2: imem[k] = rTypeWord(pickFunct(), pickReg(), pickReg(), pickReg());
                3:       imem[k] = iTypeWord(isaPkg::OpAddiu, pickReg(), pickReg(), imm);
                4:       imem[k] = iTypeWord(isaPkg::OpOri, pickReg(), pickReg(), imm);
                5:       imem[k] = iTypeWord(isaPkg::OpLui, 5'd0, pickReg(), imm);
                6:       imem[k] = iTypeWord(isaPkg::OpLw, 5'd0, pickReg(), offset);
                7:       imem[k] = iTypeWord(isaPkg::OpSw, 5'd0, pickReg(), offset);
                8:       imem[k] = iTypeWord(imm[0] ? isaPkg::OpBeq : isaPkg::OpBne,
                                             pickReg(), pickReg(), off);
                default: imem[k] = jumpWord(k + 1 + int'(off));
            endcase
        end
        // Register dump ahead of the self-loop left by the fill
        for (int r = 1; r <= DumpLen; r++) begin
            imem[ProgLen + r - 1] = iTypeWord(isaPkg::OpSw, 5'd0, 5'(r), 16'(r * 4));
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    task automatic setReg(input logic [4:0] idx, input logic [31:0] value);
        if (idx != 5'd0) begin
            modelRegs[idx] = value;
        end
    endtask

    task automatic runModel();
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic [31:0] addr;
        int          steps;
        bit          done;
        expAddr.delete();
        expData.delete();
        expLoad.delete();
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'h0000_0000;
        end
        pc    = ResetPc;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 4 * TotalLen) begin
            inst   = imem[pc[8:2]];
            a      = modelRegs[inst[25:21]];
            b      = modelRegs[inst[20:16]];
            sImm   = {{16{inst[15]}}, inst[15:0]};
            addr   = a + sImm;
            nextPc = pc + 32'd4;
            case (inst[31:26])
                isaPkg::OpSpecial: begin
                    case (inst[5:0])
                        isaPkg::FnAddu: setReg(inst[15:11], a + b);
                        isaPkg::FnSubu: setReg(inst[15:11], a - b);
                        isaPkg::FnAnd:  setReg(inst[15:11], a & b);
                        isaPkg::FnOr:   setReg(inst[15:11], a | b);
                        isaPkg::FnXor:  setReg(inst[15:11], a ^ b);
                        isaPkg::FnSlt:  setReg(inst[15:11],
                                               ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        default: ;
                    endcase
                end
                isaPkg::OpAddiu: setReg(inst[20:16], addr);
                isaPkg::OpOri:   setReg(inst[20:16], a | {16'h0000, inst[15:0]});
                isaPkg::OpLui:   setReg(inst[20:16], {inst[15:0], 16'h0000});
                isaPkg::OpLw: begin
                    setReg(inst[20:16], modelMem[addr[7:2]]);
                    expLoad.push_back(addr);
                end
                isaPkg::OpSw: begin
                    modelMem[addr[7:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                isaPkg::OpBeq: begin
                    if (a == b) begin
                        nextPc = nextPc + (sImm << 2);
                    end
                end
                isaPkg::OpBne: begin
                    if (a != b) begin
                        nextPc = nextPc + (sImm << 2);
                    end
                end
                isaPkg::OpJ: begin
                    done   = (inst == jumpWord(int'(pc[8:2])));
                    nextPc = {nextPc[31:28], inst[25:0], 2'b00};
                end
                default: ;
            endcase
            pc    = nextPc;
            steps = steps + 1;
        end
        if (!done) begin
            $display("Reference model never reached the final loop of program %0d", progNum);
            $display("*** TEST FAILED ***");
            $fatal(1, "Model did not finish");
        end
    endtask

    task automatic runProgram();
        logic [31:0] loopAddr;
        loopAddr = ResetPc + 32'(4 * (TotalLen - 1));
        @(negedge clk);
        rstN = 1'b0;
        buildProgram();
        for (int i = 0; i < DmemWords; i++) begin
            dmem[i]     = 32'hD000_0000 | 32'(i * 4);
            modelMem[i] = 32'hD000_0000 | 32'(i * 4);
        end
        runModel();
        storeIdx = 0;
        loadIdx  = 0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        compareValues($sformatf("prog%0d reset fetch address", progNum), ResetPc, instAddr);
        // Wait for every store and then for the final loop
        while (storeIdx < expAddr.size()) begin
            @(negedge clk);
        end
        compareValues($sformatf("prog%0d load count", progNum),
                      32'(expLoad.size()), 32'(loadIdx));
        while (instAddr !== loopAddr) begin
            @(negedge clk);
        end
    endtask

    initial begin
        seed       = 94815;
        clk        = 1'b0;
        rstN       = 1'b0;
        instData   = 32'h0000_0000;
        memRData   = 32'h0000_0000;
        pendWe     = 1'b0;
        pendIdx    = 6'd0;
        pendData   = 32'h0000_0000;
        storeIdx   = 0;
        loadIdx    = 0;
        cycleCount = 0;
        progNum    = 0;
        for (int p = 0; p < NumProgs; p++) begin
            progNum = p;
            runProgram();
        end
        $display("Ran %0d random programs of %0d instructions", NumProgs, ProgLen);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- build.f
hw/isaPkg.sv
hw/pipePkg.sv
hw/fetchUnit.sv
hw/decodeUnit.sv
hw/regFile.sv
hw/hazardUnit.sv
hw/executeUnit.sv
hw/memWriteback.sv
hw/mipsCore.sv
verif/mipsCore_checker.sv
verif/mipsCore_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= mipsCore_tb
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
SIM_FLAGS  ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
FAIL_MSG   := *** TEST FAILED ***
PASS_MSG   := *** TEST PASSED ***

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
